/* vlog.f */
+incdir+src
src/servo_pkg.sv
src/iir_first_order.sv
src/adc_front_end.sv
src/dac_sample_fifo.sv
src/spi_bit_timer.sv
src/dac_spi_fsm.sv
src/servo_top.sv
verif/servo_tb.sv

/* Bender.yml */
package:
  name: laser_servo

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/servo_pkg.sv
      - src/iir_first_order.sv
      - src/adc_front_end.sv
      - src/dac_sample_fifo.sv
      - src/spi_bit_timer.sv
      - src/dac_spi_fsm.sv
      - src/servo_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/servo_tb.sv

/* verif/servo_tb.sv */
`timescale 1ns/1ps
`include "servo_params.svh"

module servo_tb;

	logic clk1;
	logic i_reset;
	servo_pkg::adc_sample_t adc0;
	servo_pkg::adc_sample_t adc1;
	logic adc_valid;
	servo_pkg::servo_cfg_t cfg;
	servo_pkg::gain_t afe_gain0;
	servo_pkg::gain_t afe_gain1;
	logic dac_scs;
	logic dac_sck;
	logic dac_sdi;
	logic dac_ldac;
	logic overrun;

	integer seed = 32'hae47;
	int value_errors;
	int protocol_errors;
	int timeout_errors;
	bit timed_out;

	// captured frames and words from the reference model
	logic [`FRAME_BITS-1:0] frames[$];
	servo_pkg::dac_word_t expected[$];
	logic [`FRAME_BITS-1:0] shift_in;
	int edge_cnt;
	bit in_frame;
	bit ldac_due;
	// model filter history per channel
	servo_pkg::signal_t x_hist[2];
	servo_pkg::signal_t y_hist[2];

	initial begin
		clk1 = 1'b0;
		forever #10 clk1 = ~clk1;
	end

	servo_top i_dut (
		.i_clk1     (clk1),
		.i_reset    (i_reset),
		.i_adc0     (adc0),
		.i_adc1     (adc1),
		.i_adc_valid(adc_valid),
		.i_cfg      (cfg),
		.o_afe_gain0(afe_gain0),
		.o_afe_gain1(afe_gain1),
		.o_dac_scs  (dac_scs),
		.o_dac_sck  (dac_sck),
		.o_dac_sdi  (dac_sdi),
		.o_dac_ldac (dac_ldac),
		.o_overrun  (overrun)
	);

	// SCK may only move inside a frame
	sck_in_frame: assert property (@(posedge clk1) disable iff (i_reset)
		(dac_sck != $past(dac_sck)) |-> !dac_scs)
		else begin
			protocol_errors++;
			$display("SCK toggled while SCS was high at %0t", $time);
		end

	task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
		assert (act === exp) else begin
			value_errors++;
			$display("MISMATCH time=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
		end
	endtask

	task automatic step();
		@(posedge clk1);
		#2;
	endtask

	////////////////////
	// reference model
	////////////////////
	function automatic servo_pkg::signal_t scaled_product(servo_pkg::coef_t c,
		servo_pkg::signal_t v);
		logic signed [63:0] p;
		p = 64'(c) * 64'(v);
		p = p >>> `COEF_FRAC;
		return p[`SIGNAL_W-1:0];
	endfunction

	function automatic servo_pkg::signal_t filter_model(int ch, servo_pkg::adc_sample_t s,
		servo_pkg::chan_cfg_t c);
		servo_pkg::signal_t x;
		servo_pkg::signal_t y;
		// sign extend then scale up to the signal width
		x = servo_pkg::signal_t'(s) <<< (`SIGNAL_W - `ADC_W);
		if (c.filter_on) begin
			y = scaled_product(c.b0, x) + scaled_product(c.b1, x_hist[ch])
				+ scaled_product(c.a1, y_hist[ch]);
			x_hist[ch] = x;
			y_hist[ch] = y;
		end else begin
			y = x;
			x_hist[ch] = '0;
			y_hist[ch] = '0;
		end
		return y;
	endfunction

	function automatic servo_pkg::adc_sample_t rand_sample();
		logic [31:0] r;
		r = $random(seed);
		return r[`ADC_W-1:0];
	endfunction

	function automatic servo_pkg::coef_t rand_coef();
		int v;
		// small magnitude below a quarter
		v = $random(seed) % 16384;
		return v[`COEF_W-1:0];
	endfunction

	task automatic rand_cfg();
		logic [127:0] r;
		r = {$random(seed), $random(seed), $random(seed), $random(seed)};
		cfg = r[$bits(cfg)-1:0];
	endtask

	// drive one pair for one cycle and log the expected word
	task automatic send_pair(servo_pkg::adc_sample_t s0, servo_pkg::adc_sample_t s1);
		servo_pkg::signal_t d;
		adc0 = s0;
		adc1 = s1;
		adc_valid = 1'b1;
		d = filter_model(0, s0, cfg.ch0) - filter_model(1, s1, cfg.ch1);
		expected.push_back(d[`SIGNAL_W-1 -: `DAC_W]);
		step();
		adc_valid = 1'b0;
	endtask

	////////////////////
	// frame capture
	////////////////////
	always @(negedge dac_scs) begin
		assert (!ldac_due) else begin
			protocol_errors++;
			$display("frame started before the previous LDAC pulse at %0t", $time);
		end
		in_frame = 1'b1;
		edge_cnt = 0;
		shift_in = '0;
	end

	// DAC samples SDI on the falling SCK edge
	always @(negedge dac_sck) begin
		if (in_frame && !dac_scs) begin
			shift_in = {shift_in[`FRAME_BITS-2:0], dac_sdi};
			edge_cnt++;
		end
	end

	always @(posedge dac_scs) begin
		if (in_frame) begin
			check_value("sck_falling_edges", `FRAME_BITS, edge_cnt);
			frames.push_back(shift_in);
			in_frame = 1'b0;
			ldac_due = 1'b1;
		end
	end

	always @(negedge dac_ldac) begin
		assert (ldac_due) else begin
			protocol_errors++;
			$display("LDAC pulse without a finished frame at %0t", $time);
		end
		ldac_due = 1'b0;
	end

	////////////////////
	// waits and checks
	////////////////////
	task automatic wait_frames(int n, int limit);
		int cycles;
		cycles = 0;
		while (frames.size() < n && cycles < limit) begin
			step();
			cycles++;
		end
		if (frames.size() < n) begin
			timeout_errors++;
			timed_out = 1'b1;
			$display("timeout at %0t, only %0d of %0d frames arrived", $time, frames.size(), n);
		end
	endtask

	// link is drained once SCS and LDAC stay high for a while
	task automatic wait_idle(int quiet, int limit);
		int cycles;
		int idle;
		cycles = 0;
		idle = 0;
		while (idle < quiet && cycles < limit) begin
			step();
			cycles++;
			idle = (dac_scs && dac_ldac) ? idle + 1 : 0;
		end
		if (idle < quiet) begin
			timeout_errors++;
			timed_out = 1'b1;
			$display("timeout at %0t, serial link never went idle", $time);
		end
	endtask

	task automatic check_in_order();
		check_value("frame_count", expected.size(), frames.size());
		foreach (frames[i]) begin
			if (i < expected.size()) begin
				check_value("frame_header", `DAC_CMD, frames[i][`FRAME_BITS-1 -: 8]);
				check_value("frame_data", expected[i], frames[i][`DAC_W-1:0]);
			end
		end
	endtask

	// dropped words may be missing but order must hold
	task automatic check_subsequence();
		int k;
		k = 0;
		foreach (frames[i]) begin
			check_value("frame_header", `DAC_CMD, frames[i][`FRAME_BITS-1 -: 8]);
			while (k < expected.size() && expected[k] !== frames[i][`DAC_W-1:0]) begin
				k++;
			end
			assert (k < expected.size()) else begin
				value_errors++;
				$display("frame %0d word %0h is not in the expected order", i, frames[i][15:0]);
			end
			k++;
		end
	endtask

	////////////////////
	// test sequence
	////////////////////
	initial begin
		servo_pkg::gain_t g0;
		servo_pkg::gain_t g1;
		i_reset = 1'b1;
		adc0 = '0;
		adc1 = '0;
		adc_valid = 1'b0;
		cfg = '0;
		value_errors = 0;
		protocol_errors = 0;
		timeout_errors = 0;
		timed_out = 1'b0;
		in_frame = 1'b0;
		ldac_due = 1'b0;
		x_hist = '{default: '0};
		y_hist = '{default: '0};
		repeat (8) @(posedge clk1);
		#2;
		i_reset = 1'b0;
		step();

		// reset values
		check_value("o_dac_scs", 1'b1, dac_scs);
		check_value("o_dac_ldac", 1'b1, dac_ldac);
		check_value("o_dac_sck", 1'b0, dac_sck);
		check_value("o_dac_sdi", 1'b0, dac_sdi);
		check_value("o_overrun", 1'b0, overrun);
		check_value("o_afe_gain0", 2'd3, afe_gain0);
		check_value("o_afe_gain1", 2'd3, afe_gain1);

		// gain is the inverse code two cycles behind
		g0 = 2'd3;
		g1 = 2'd3;
		repeat (8) begin
			rand_cfg();
			step();
			// only the config register has moved yet
			check_value("o_afe_gain0", g0, afe_gain0);
			check_value("o_afe_gain1", g1, afe_gain1);
			g0 = 2'd3 - cfg.ch0.gain;
			g1 = 2'd3 - cfg.ch1.gain;
			step();
			check_value("o_afe_gain0", g0, afe_gain0);
			check_value("o_afe_gain1", g1, afe_gain1);
		end

		// bypass path with pairs well apart
		cfg = '0;
		repeat (4) step();
		frames.delete();
		expected.delete();
		repeat (4) begin
			send_pair(rand_sample(), rand_sample());
			repeat (49) step();
		end
		wait_frames(4, 2000);
		wait_idle(20, 1000);
		if (!timed_out) begin
			check_in_order();
		end

		// filters on with small random coefficients
		cfg.ch0.filter_on = 1'b1;
		cfg.ch0.a1 = rand_coef();
		cfg.ch0.b0 = rand_coef();
		cfg.ch0.b1 = rand_coef();
		cfg.ch1.filter_on = 1'b1;
		cfg.ch1.a1 = rand_coef();
		cfg.ch1.b0 = rand_coef();
		cfg.ch1.b1 = rand_coef();
		repeat (4) step();
		frames.delete();
		expected.delete();
		repeat (4) begin
			send_pair(rand_sample(), rand_sample());
			repeat (49) step();
		end
		wait_frames(4, 2000);
		wait_idle(20, 1000);
		if (!timed_out) begin
			check_in_order();
		end
		check_value("o_overrun", 1'b0, overrun);

		// back-to-back burst runs out of credits
		frames.delete();
		expected.delete();
		repeat (`FIFO_DEPTH + 8) begin
			send_pair(rand_sample(), rand_sample());
		end
		wait_frames(`FIFO_DEPTH, 5000);
		wait_idle(20, 5000);
		check_value("o_overrun", 1'b1, overrun);
		if (!timed_out) begin
			check_subsequence();
		end

		// the last frame needs its LDAC pulse too
		assert (!ldac_due) else begin
			protocol_errors++;
			$display("no LDAC pulse after the last frame at %0t", $time);
		end

		$display("errors: value %0d, protocol %0d, timeout %0d",
			value_errors, protocol_errors, timeout_errors);
		if (value_errors + protocol_errors + timeout_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* src/servo_top.sv */
`timescale 1ns/1ps
`include "servo_params.svh"

module servo_top (
	input  logic                   i_clk1,
	input  logic                   i_reset,
	// paired ADC samples
	input  servo_pkg::adc_sample_t i_adc0,
	input  servo_pkg::adc_sample_t i_adc1,
	input  logic                   i_adc_valid,
	// flat config, sampled every cycle
	input  servo_pkg::servo_cfg_t  i_cfg,
	// AFE gain select
	output servo_pkg::gain_t       o_afe_gain0,
	output servo_pkg::gain_t       o_afe_gain1,
	// serial DAC, SCS and LDAC active low
	output logic                   o_dac_scs,
	output logic                   o_dac_sck,
	output logic                   o_dac_sdi,
	output logic                   o_dac_ldac,
	// sticky, a difference was dropped
	output logic                   o_overrun
);

	// front end to queue
	servo_pkg::dac_word_t fe_word;
	logic fe_word_valid;
	logic fifo_credit;
	// queue to serial link
	servo_pkg::dac_word_t fifo_head;
	logic fifo_empty;
	logic fsm_pop;
	// bit timing
	logic spi_run;
	logic spi_tick;
	logic [`BIT_IDX_W-1:0] spi_bit_idx;

	////////////////////
	// analog path
	////////////////////
	adc_front_end u_front_end (
		.i_clk1      (i_clk1),
		.i_reset     (i_reset),
		.i_adc0      (i_adc0),
		.i_adc1      (i_adc1),
		.i_adc_valid (i_adc_valid),
		.i_cfg       (i_cfg),
		.i_credit    (fifo_credit),
		.o_afe_gain0 (o_afe_gain0),
		.o_afe_gain1 (o_afe_gain1),
		.o_word      (fe_word),
		.o_word_valid(fe_word_valid),
		.o_overrun   (o_overrun)
	);

	// absorbs the rate gap between samples and DAC frames
	dac_sample_fifo u_fifo (
		.i_clk1  (i_clk1),
		.i_reset (i_reset),
		.i_word  (fe_word),
		.i_push  (fe_word_valid),
		.i_pop   (fsm_pop),
		.o_head  (fifo_head),
		.o_empty (fifo_empty),
		.o_credit(fifo_credit)
	);

	////////////////////
	// serial DAC
	////////////////////
	spi_bit_timer u_timer (
		.i_clk1   (i_clk1),
		.i_reset  (i_reset),
		.i_run    (spi_run),
		.o_tick   (spi_tick),
		.o_bit_idx(spi_bit_idx)
	);

	dac_spi_fsm u_spi (
		.i_clk1   (i_clk1),
		.i_reset  (i_reset),
		.i_empty  (fifo_empty),
		.i_head   (fifo_head),
		.o_pop    (fsm_pop),
		.i_tick   (spi_tick),
		.i_bit_idx(spi_bit_idx),
		.o_run    (spi_run),
		.o_scs    (o_dac_scs),
		.o_sck    (o_dac_sck),
		.o_sdi    (o_dac_sdi),
		.o_ldac   (o_dac_ldac)
	);

endmodule

/* src/dac_spi_fsm.sv */
`timescale 1ns/1ps
`include "servo_params.svh"

module dac_spi_fsm (
	input  logic                  i_clk1,
	input  logic                  i_reset,
	input  logic                  i_empty,
	input  servo_pkg::dac_word_t  i_head,
	output logic                  o_pop,
	input  logic                  i_tick,
	input  logic [`BIT_IDX_W-1:0] i_bit_idx,
	output logic                  o_run,
	output logic                  o_scs,
	output logic                  o_sck,
	output logic                  o_sdi,
	output logic                  o_ldac
);

	servo_pkg::spi_state_t state;
	// word taken from the queue in IDLE
	servo_pkg::dac_word_t word_q;
	logic [`FRAME_BITS-1:0] frame_sr;
	// last falling SCK edge has gone out
	logic last_edge;
	logic [`DIV_W-1:0] latch_cnt;

	assign o_pop = (state == servo_pkg::IDLE) && !i_empty;
	assign o_run = (state == servo_pkg::SHIFT);

	always_ff @(posedge i_clk1) begin
		if (o_pop) begin
			word_q <= i_head;
		end
		if (state == servo_pkg::LOAD) begin
			frame_sr <= {`DAC_CMD, word_q};
		end else if (o_run && i_tick && !o_sck) begin
			// msb first, next bit moves up on each rising edge
			frame_sr <= {frame_sr[`FRAME_BITS-2:0], 1'b0};
		end
	end

	always_ff @(posedge i_clk1) begin
		if (i_reset) begin
			state <= servo_pkg::IDLE;
			o_scs <= 1'b1;
			o_sck <= 1'b0;
			o_sdi <= 1'b0;
			o_ldac <= 1'b1;
			last_edge <= 1'b0;
			latch_cnt <= '0;
		end else begin
			case (state)
				servo_pkg::IDLE: begin
					if (!i_empty) begin
						state <= servo_pkg::LOAD;
					end
				end
				servo_pkg::LOAD: begin
					o_scs <= 1'b0;
					state <= servo_pkg::SHIFT;
				end
				servo_pkg::SHIFT: begin
					if (last_edge) begin
						// SCK has been low for a while, close the frame
						o_scs <= 1'b1;
						o_sdi <= 1'b0;
						last_edge <= 1'b0;
						latch_cnt <= '0;
						state <= servo_pkg::LATCH;
					end else if (i_tick) begin
						o_sck <= !o_sck;
						// data changes with the rising edge, DAC samples on the fall
						if (!o_sck) begin
							o_sdi <= frame_sr[`FRAME_BITS-1];
						end
						if (o_sck && i_bit_idx == `FRAME_BITS - 1) begin
							last_edge <= 1'b1;
						end
					end
				end
				servo_pkg::LATCH: begin
					// one idle cycle after SCS, then LDAC low for SCK_DIV cycles
					if (latch_cnt == `SCK_DIV) begin
						o_ldac <= 1'b1;
						state <= servo_pkg::IDLE;
					end else begin
						o_ldac <= 1'b0;
						latch_cnt <= latch_cnt + 1'b1;
					end
				end
				default: state <= servo_pkg::IDLE;
			endcase
		end
	end

endmodule

/* src/spi_bit_timer.sv */
`timescale 1ns/1ps
`include "servo_params.svh"

module spi_bit_timer (
	input  logic                  i_clk1,
	input  logic                  i_reset,
	input  logic                  i_run,
	output logic                  o_tick,
	output logic [`BIT_IDX_W-1:0] o_bit_idx
);

	// clk1 cycles within one SCK half-period
	logic [`DIV_W-1:0] div_cnt;
	// half-periods done in the current frame
	logic [`BIT_IDX_W:0] half_cnt;

	// tick in the middle of the divider count, keeps SCK edges
	// clear of the SCS edges at both ends of the frame
	assign o_tick = i_run && (div_cnt == `SCK_DIV / 2);

	// two half-periods per bit
	assign o_bit_idx = half_cnt[`BIT_IDX_W:1];

	always_ff @(posedge i_clk1) begin
		if (i_reset) begin
			div_cnt <= '0;
			half_cnt <= '0;
		end else if (!i_run) begin
			// idle between frames
			div_cnt <= '0;
			half_cnt <= '0;
		end else begin
			div_cnt <= (div_cnt == `SCK_DIV - 1) ? '0 : div_cnt + 1'b1;
			if (o_tick) begin
				half_cnt <= half_cnt + 1'b1;
			end
		end
	end

endmodule

/* src/dac_sample_fifo.sv */
`timescale 1ns/1ps
`include "servo_params.svh"

module dac_sample_fifo (
	input  logic                 i_clk1,
	input  logic                 i_reset,
	input  servo_pkg::dac_word_t i_word,
	input  logic                 i_push,
	input  logic                 i_pop,
	output servo_pkg::dac_word_t o_head,
	output logic                 o_empty,
	output logic                 o_credit
);

	servo_pkg::dac_word_t mem [`FIFO_DEPTH];
	logic [`FIFO_PTR_W-1:0] wr_ptr;
	logic [`FIFO_PTR_W-1:0] rd_ptr;
	logic [`FIFO_CNT_W-1:0] count;
	logic pop_ok;

	// sender holds credits, so a push always finds room
	assign pop_ok = i_pop && !o_empty;
	assign o_empty = (count == '0);
	assign o_head = mem[rd_ptr];

	always_ff @(posedge i_clk1) begin
		if (i_push) begin
			mem[wr_ptr] <= i_word;
		end
	end

	always_ff @(posedge i_clk1) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			o_credit <= 1'b0;
		end else begin
			// pointers wrap at the queue depth
			if (i_push) begin
				wr_ptr <= (wr_ptr == `FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= (rd_ptr == `FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			end
			case ({i_push, pop_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// one credit back per word taken
			o_credit <= pop_ok;
		end
	end

endmodule

/* src/adc_front_end.sv */
`timescale 1ns/1ps
`include "servo_params.svh"

module adc_front_end (
	input  logic                   i_clk1,
	input  logic                   i_reset,
	input  servo_pkg::adc_sample_t i_adc0,
	input  servo_pkg::adc_sample_t i_adc1,
	input  logic                   i_adc_valid,
	input  servo_pkg::servo_cfg_t  i_cfg,
	input  logic                   i_credit,
	output servo_pkg::gain_t       o_afe_gain0,
	output servo_pkg::gain_t       o_afe_gain1,
	output servo_pkg::dac_word_t   o_word,
	output logic                   o_word_valid,
	output logic                   o_overrun
);

	servo_pkg::servo_cfg_t cfg_q;
	servo_pkg::adc_sample_t adc0_q;
	servo_pkg::adc_sample_t adc1_q;
	logic cap_valid;
	servo_pkg::signal_t filt0;
	servo_pkg::signal_t filt1;
	logic filt0_valid;
	logic filt1_valid;
	servo_pkg::signal_t diff;
	logic send;
	logic [`FIFO_CNT_W-1:0] credit_cnt;

	// input capture, config and AFE gain
	always_ff @(posedge i_clk1) begin
		if (i_reset) begin
			cfg_q <= '0;
			cap_valid <= 1'b0;
			o_afe_gain0 <= {`GAIN_W{1'b1}};
			o_afe_gain1 <= {`GAIN_W{1'b1}};
		end else begin
			cfg_q <= i_cfg;
			cap_valid <= i_adc_valid;
			// the AFE wants the inverse of the configured code
			o_afe_gain0 <= {`GAIN_W{1'b1}} - cfg_q.ch0.gain;
			o_afe_gain1 <= {`GAIN_W{1'b1}} - cfg_q.ch1.gain;
		end
	end

	always_ff @(posedge i_clk1) begin
		if (i_adc_valid) begin
			adc0_q <= i_adc0;
			adc1_q <= i_adc1;
		end
	end

	iir_first_order u_iir0 (
		.i_clk1  (i_clk1),
		.i_reset (i_reset),
		.i_valid (cap_valid),
		.i_sample(adc0_q),
		.i_cfg   (cfg_q.ch0),
		.o_valid (filt0_valid),
		.o_signal(filt0)
	);

	iir_first_order u_iir1 (
		.i_clk1  (i_clk1),
		.i_reset (i_reset),
		.i_valid (cap_valid),
		.i_sample(adc1_q),
		.i_cfg   (cfg_q.ch1),
		.o_valid (filt1_valid),
		.o_signal(filt1)
	);

	////////////////////
	// difference and credits
	////////////////////
	assign diff = filt0 - filt1;
	// a word goes out only with a credit in hand
	assign send = filt0_valid && filt1_valid && (credit_cnt != '0);

	always_ff @(posedge i_clk1) begin
		if (i_reset) begin
			o_word_valid <= 1'b0;
			o_overrun <= 1'b0;
			credit_cnt <= `FIFO_CNT_W'(`FIFO_DEPTH);
		end else begin
			o_word_valid <= send;
			// no credit, the difference is lost
			if (filt0_valid && filt1_valid && !send) begin
				o_overrun <= 1'b1;
			end
			case ({i_credit, send})
				2'b10: credit_cnt <= credit_cnt + 1'b1;
				2'b01: credit_cnt <= credit_cnt - 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	always_ff @(posedge i_clk1) begin
		if (send) begin
			o_word <= diff[`SIGNAL_W-1 -: `DAC_W];
		end
	end

endmodule

/* src/iir_first_order.sv */
`timescale 1ns/1ps
`include "servo_params.svh"

module iir_first_order (
	input  logic                  i_clk1,
	input  logic                  i_reset,
	input  logic                  i_valid,
	input  servo_pkg::adc_sample_t i_sample,
	input  servo_pkg::chan_cfg_t   i_cfg,
	output logic                  o_valid,
	output servo_pkg::signal_t     o_signal
);

	// sample moved up to the top of the signal word
	servo_pkg::signal_t x_ext;
	// filter state, previous input and previous output
	servo_pkg::signal_t x_prev;
	servo_pkg::signal_t y_prev;
	// full precision products
	logic signed [`COEF_W+`SIGNAL_W-1:0] prod_b0;
	logic signed [`COEF_W+`SIGNAL_W-1:0] prod_b1;
	logic signed [`COEF_W+`SIGNAL_W-1:0] prod_a1;
	// stage 1 registers
	logic s1_valid;
	logic s1_on;
	servo_pkg::signal_t s1_b0x;
	servo_pkg::signal_t s1_b1x;
	servo_pkg::signal_t s1_x;
	servo_pkg::coef_t s1_a1;
	// stage 2 sum
	servo_pkg::signal_t sum;

	assign x_ext = {i_sample, {(`SIGNAL_W - `ADC_W){1'b0}}};

	// feed-forward terms from the current config
	assign prod_b0 = $signed(i_cfg.b0) * x_ext;
	assign prod_b1 = $signed(i_cfg.b1) * x_prev;
	// feedback term, y_prev already holds the last output even back to back
	assign prod_a1 = s1_a1 * y_prev;

	// each product is truncated after the arithmetic shift
	assign sum = s1_b0x + s1_b1x + prod_a1[`COEF_FRAC +: `SIGNAL_W];

	////////////////////
	// control and state
	////////////////////
	always_ff @(posedge i_clk1) begin
		if (i_reset) begin
			s1_valid <= 1'b0;
			o_valid <= 1'b0;
			x_prev <= '0;
			y_prev <= '0;
		end else begin
			s1_valid <= i_valid;
			o_valid <= s1_valid;
			// state only moves on a new sample
			if (i_valid) begin
				x_prev <= i_cfg.filter_on ? x_ext : '0;
			end
			// bypass clears the history
			if (s1_valid) begin
				y_prev <= s1_on ? sum : '0;
			end
		end
	end

	////////////////////
	// datapath
	////////////////////
	always_ff @(posedge i_clk1) begin
		if (i_valid) begin
			s1_b0x <= prod_b0[`COEF_FRAC +: `SIGNAL_W];
			s1_b1x <= prod_b1[`COEF_FRAC +: `SIGNAL_W];
			s1_x <= x_ext;
			s1_a1 <= i_cfg.a1;
			s1_on <= i_cfg.filter_on;
		end
		if (s1_valid) begin
			o_signal <= s1_on ? sum : s1_x;
		end
	end

endmodule

/* src/servo_pkg.sv */
`include "servo_params.svh"

package servo_pkg;

	////////////////////
	// data widths
	////////////////////

	// signed sample straight from the ADC
	typedef logic signed [`ADC_W-1:0] adc_sample_t;
	// filtered or difference value
	typedef logic signed [`SIGNAL_W-1:0] signal_t;
	// filter coefficient, COEF_FRAC fraction bits
	typedef logic signed [`COEF_W-1:0] coef_t;
	// code sent to the serial DAC
	typedef logic [`DAC_W-1:0] dac_word_t;
	// AFE gain code
	typedef logic [`GAIN_W-1:0] gain_t;

	////////////////////
	// configuration
	////////////////////

	// one analog input channel
	typedef struct packed {
		logic filter_on;
		coef_t a1;
		coef_t b0;
		coef_t b1;
		gain_t gain;
	} chan_cfg_t;

	// both channels of the servo
	typedef struct packed {
		chan_cfg_t ch0;
		chan_cfg_t ch1;
	} servo_cfg_t;

	// DAC serial link states
	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		SHIFT,
		LATCH
	} spi_state_t;

endpackage

/* src/servo_params.svh */
`ifndef SERVO_PARAMS_SVH
`define SERVO_PARAMS_SVH

// raw ADC sample width
`define ADC_W 16
// internal signal path width
`define SIGNAL_W 24

// filter coefficients, signed fixed point
`define COEF_W 18
`define COEF_FRAC 16

// serial DAC word and frame layout
`define DAC_W 16
// command header, selects DAC channel A
`define DAC_CMD 8'h00
`define FRAME_BITS 24

// clk1 cycles per SCK half-period
`define SCK_DIV 4

// DAC queue entries, also the initial credit count
`define FIFO_DEPTH 4

// AFE gain code
`define GAIN_W 2

// derived counter widths
`define FIFO_PTR_W ($clog2(`FIFO_DEPTH))
`define FIFO_CNT_W ($clog2(`FIFO_DEPTH + 1))
`define BIT_IDX_W ($clog2(`FRAME_BITS))
`define DIV_W ($clog2(`SCK_DIV + 1))

`endif
